// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_gb_bus_fabric
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Regression passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== filelist.f ====
+incdir+verif
source/gb_bus_pkg.sv
source/gb_addr_decode.sv
source/oam_dma_engine.sv
source/bus_arbiter.sv
source/local_memories.sv
source/read_return.sv
source/gb_bus_fabric.sv
verif/tb_gb_bus_fabric.sv

// ==== source/bus_arbiter.sv ====
`timescale 1ns/1ps

module bus_arbiter import gb_bus_pkg::*; (
	input  logic               cpu_sel_rom,
	input  logic               cpu_sel_vram,
	input  logic               cpu_sel_xram,
	input  logic               cpu_sel_wram,
	input  logic               cpu_sel_oam,
	input  logic               cpu_sel_hram,
	input  logic               cpu_sel_dma_reg,
	input  cpu_addr_t          cpu_adr,
	input  logic [DATA_W-1:0]  cpu_dout,
	input  logic               cpu_rd,
	input  logic               cpu_wr,
	input  logic               dma_sel_rom,
	input  logic               dma_sel_vram,
	input  logic               dma_sel_xram,
	input  logic               dma_sel_wram,
	input  cpu_addr_t          src_adr,
	input  logic               src_rd,
	input  logic [OAM_AW-1:0]  oam_index,
	input  logic               oam_wr,
	input  logic [DATA_W-1:0]  oam_wdata,
	input  logic               dma_active,
	input  logic [ADDR_W-1:0]  ppu_adr,
	input  logic               ppu_rd,
	input  logic               ppu_needs_vram,
	input  logic               ppu_needs_oam,
	output logic [VRAM_AW-1:0] vram_adr,
	output logic               vram_rd,
	output logic               vram_wr,
	output logic [DATA_W-1:0]  vram_wdata,
	output logic [OAM_AW-1:0]  oam_adr,
	output logic               oam_rd,
	output logic               oam_wr_en,
	output logic [DATA_W-1:0]  oam_data_in,
	output logic [HRAM_AW-1:0] hram_adr,
	output logic               hram_rd,
	output logic               hram_wr,
	output logic [DATA_W-1:0]  hram_wdata,
	output logic [ADDR_W-1:0]  ext_adr,
	output logic               ext_rd,
	output logic               ext_wr,
	output logic [DATA_W-1:0]  ext_dout,
	output logic               cs_rom,
	output logic               cs_xram,
	output logic               cs_wram,
	output logic               dma_reg_wr,
	output logic [SRC_W-1:0]   cpu_src,
	output logic [SRC_W-1:0]   dma_src_ext,
	output logic [1:0]         ppu_src
);

	logic cpu_ext;
	logic dma_ext;
	logic cpu_vram_ok;
	logic cpu_oam_ok;
	logic cpu_ext_ok;

	assign cpu_ext = cpu_sel_rom || cpu_sel_xram || cpu_sel_wram;
	assign dma_ext = dma_sel_rom || dma_sel_xram || dma_sel_wram;

	assign cpu_vram_ok = cpu_sel_vram && !ppu_needs_vram && !dma_sel_vram;
	assign cpu_oam_ok  = cpu_sel_oam && !ppu_needs_oam && !dma_active;
	assign cpu_ext_ok  = cpu_ext && !dma_ext;

	always_comb begin
		vram_adr = cpu_adr.flat[VRAM_AW-1:0];
		vram_rd  = cpu_vram_ok && cpu_rd;
		vram_wr  = cpu_vram_ok && cpu_wr;
		if (ppu_needs_vram) begin
			vram_adr = ppu_adr[VRAM_AW-1:0];
			vram_rd  = ppu_rd;
		end else if (dma_sel_vram) begin
			vram_adr = src_adr.flat[VRAM_AW-1:0];
			vram_rd  = src_rd;
		end
	end

	always_comb begin
		oam_adr     = cpu_adr.part.offset;
		oam_rd      = cpu_oam_ok && cpu_rd;
		oam_wr_en   = cpu_oam_ok && cpu_wr;
		oam_data_in = cpu_dout;
		if (ppu_needs_oam) begin
			oam_adr = ppu_adr[OAM_AW-1:0];
			oam_rd  = ppu_rd;
		end else if (dma_active) begin
			oam_adr     = oam_index;
			oam_wr_en   = oam_wr;
			oam_data_in = oam_wdata;
		end
	end

	assign vram_wdata = cpu_dout;
	assign hram_adr   = cpu_adr.part.offset[HRAM_AW-1:0];   // 0x80 to 0xFE map to 0 to 126.
	assign hram_rd    = cpu_sel_hram && cpu_rd;
	assign hram_wr    = cpu_sel_hram && cpu_wr;
	assign hram_wdata = cpu_dout;

	// The DMA engine only reads, so the write strobe always belongs to the CPU.
	assign ext_adr  = dma_ext ? src_adr.flat : cpu_adr.flat;
	assign ext_rd   = dma_ext ? src_rd : cpu_ext && cpu_rd;
	assign ext_wr   = cpu_ext_ok && cpu_wr;
	assign ext_dout = cpu_dout;
	assign cs_rom   = dma_ext ? dma_sel_rom : cpu_sel_rom;
	assign cs_xram  = dma_ext ? dma_sel_xram : cpu_sel_xram;
	assign cs_wram  = dma_ext ? dma_sel_wram : cpu_sel_wram;

	assign dma_reg_wr = cpu_sel_dma_reg && cpu_wr;

	always_comb begin
		cpu_src = SRC_NONE;
		if (cpu_rd) begin
			if (cpu_vram_ok)
				cpu_src = SRC_VRAM;
			else if (cpu_oam_ok)
				cpu_src = SRC_OAM;
			else if (cpu_sel_hram)
				cpu_src = SRC_HRAM;
			else if (cpu_ext_ok)
				cpu_src = SRC_EXT;
			else if (cpu_sel_dma_reg)
				cpu_src = SRC_DMA_REG;
		end
	end

	always_comb begin
		dma_src_ext = SRC_NONE;   // A source blocked by the pixel unit reads as open bus.
		if (dma_sel_vram && !ppu_needs_vram)
			dma_src_ext = SRC_VRAM;
		else if (dma_ext)
			dma_src_ext = SRC_EXT;
	end

	assign ppu_src = {ppu_rd && ppu_needs_oam, ppu_rd && ppu_needs_vram};

endmodule

// ==== source/gb_addr_decode.sv ====
`timescale 1ns/1ps

module gb_addr_decode import gb_bus_pkg::*; (
	input  cpu_addr_t adr,
	input  logic      enable,
	output logic      sel_rom,
	output logic      sel_vram,
	output logic      sel_xram,
	output logic      sel_wram,
	output logic      sel_oam,
	output logic      sel_hram,
	output logic      sel_dma_reg
);

	logic io_page;
	logic in_hram;

	assign io_page = adr.part.page == IO_PAGE;
	assign in_hram = adr.part.offset >= HRAM_LOW && adr.part.offset <= HRAM_HIGH;

	assign sel_rom  = enable && adr.flat <= ROM_END;
	assign sel_vram = enable && adr.flat >= VRAM_BASE && adr.flat <= VRAM_END;
	assign sel_xram = enable && adr.flat >= XRAM_BASE && adr.flat <= XRAM_END;
	assign sel_wram = enable && adr.flat >= WRAM_BASE && adr.flat <= WRAM_END;
	assign sel_oam  = enable && adr.flat >= OAM_BASE && adr.flat <= OAM_END;

	// The rest of the I/O page, including 0xFFFF, stays unselected.
	assign sel_hram    = enable && io_page && in_hram;
	assign sel_dma_reg = enable && io_page && adr.part.offset == DMA_REG_OFFSET;

endmodule

// ==== source/gb_bus_fabric.sv ====
`timescale 1ns/1ps

module gb_bus_fabric import gb_bus_pkg::*; (
	input  logic              gbclk,
	input  logic              reset,
	input  cpu_addr_t         cpu_adr,
	input  logic [DATA_W-1:0] cpu_dout,
	input  logic              cpu_rd,
	input  logic              cpu_wr,
	output logic [DATA_W-1:0] cpu_din,
	input  logic [ADDR_W-1:0] ppu_adr,
	input  logic              ppu_rd,
	input  logic              ppu_needs_vram,
	input  logic              ppu_needs_oam,
	output logic [DATA_W-1:0] ppu_vram_data,
	output logic [DATA_W-1:0] ppu_oam_data,
	output logic [ADDR_W-1:0] ext_adr,
	output logic              ext_rd,
	output logic              ext_wr,
	output logic [DATA_W-1:0] ext_dout,
	output logic              cs_rom,
	output logic              cs_xram,
	output logic              cs_wram,
	input  logic [DATA_W-1:0] ext_din,
	output logic              dma_active
);

	logic cpu_sel_rom, cpu_sel_vram, cpu_sel_xram, cpu_sel_wram;
	logic cpu_sel_oam, cpu_sel_hram, cpu_sel_dma_reg;
	logic dma_sel_rom, dma_sel_vram, dma_sel_xram, dma_sel_wram;

	cpu_addr_t          src_adr;
	logic               src_rd;
	logic [OAM_AW-1:0]  oam_index;
	logic               oam_wr;
	logic [DATA_W-1:0]  oam_wdata;
	logic [DATA_W-1:0]  dma_reg;
	logic               dma_reg_wr;
	logic [DATA_W-1:0]  dma_src_data;
	logic [VRAM_AW-1:0] vram_adr;
	logic               vram_rd, vram_wr;
	logic [DATA_W-1:0]  vram_wdata, vram_rdata;
	logic [OAM_AW-1:0]  oam_adr;
	logic               oam_rd, oam_wr_en;
	logic [DATA_W-1:0]  oam_data_in, oam_rdata;
	logic [HRAM_AW-1:0] hram_adr;
	logic               hram_rd, hram_wr;
	logic [DATA_W-1:0]  hram_wdata, hram_rdata;
	logic [SRC_W-1:0]   cpu_src, dma_src_ext;
	logic [1:0]         ppu_src;

	gb_addr_decode u_cpu_decode (
		.adr(cpu_adr), .enable(cpu_rd || cpu_wr),
		.sel_rom(cpu_sel_rom), .sel_vram(cpu_sel_vram), .sel_xram(cpu_sel_xram),
		.sel_wram(cpu_sel_wram), .sel_oam(cpu_sel_oam), .sel_hram(cpu_sel_hram),
		.sel_dma_reg(cpu_sel_dma_reg)
	);

	// DMA sources in OAM or the I/O page read as open bus.
	gb_addr_decode u_dma_decode (
		.adr(src_adr), .enable(src_rd),
		.sel_rom(dma_sel_rom), .sel_vram(dma_sel_vram), .sel_xram(dma_sel_xram),
		.sel_wram(dma_sel_wram), .sel_oam(), .sel_hram(), .sel_dma_reg()
	);

	oam_dma_engine u_oam_dma_engine (
		.gbclk(gbclk), .reset(reset), .reg_write(dma_reg_wr), .reg_data(cpu_dout),
		.src_data(dma_src_data), .src_adr(src_adr), .src_rd(src_rd),
		.oam_index(oam_index), .oam_wr(oam_wr), .oam_wdata(oam_wdata),
		.dma_active(dma_active), .dma_reg(dma_reg)
	);

	bus_arbiter u_bus_arbiter (
		.cpu_sel_rom(cpu_sel_rom), .cpu_sel_vram(cpu_sel_vram),
		.cpu_sel_xram(cpu_sel_xram), .cpu_sel_wram(cpu_sel_wram),
		.cpu_sel_oam(cpu_sel_oam), .cpu_sel_hram(cpu_sel_hram),
		.cpu_sel_dma_reg(cpu_sel_dma_reg), .cpu_adr(cpu_adr), .cpu_dout(cpu_dout),
		.cpu_rd(cpu_rd), .cpu_wr(cpu_wr),
		.dma_sel_rom(dma_sel_rom), .dma_sel_vram(dma_sel_vram),
		.dma_sel_xram(dma_sel_xram), .dma_sel_wram(dma_sel_wram),
		.src_adr(src_adr), .src_rd(src_rd), .oam_index(oam_index), .oam_wr(oam_wr),
		.oam_wdata(oam_wdata), .dma_active(dma_active),
		.ppu_adr(ppu_adr), .ppu_rd(ppu_rd), .ppu_needs_vram(ppu_needs_vram),
		.ppu_needs_oam(ppu_needs_oam),
		.vram_adr(vram_adr), .vram_rd(vram_rd), .vram_wr(vram_wr), .vram_wdata(vram_wdata),
		.oam_adr(oam_adr), .oam_rd(oam_rd), .oam_wr_en(oam_wr_en),
		.oam_data_in(oam_data_in),
		.hram_adr(hram_adr), .hram_rd(hram_rd), .hram_wr(hram_wr), .hram_wdata(hram_wdata),
		.ext_adr(ext_adr), .ext_rd(ext_rd), .ext_wr(ext_wr), .ext_dout(ext_dout),
		.cs_rom(cs_rom), .cs_xram(cs_xram), .cs_wram(cs_wram), .dma_reg_wr(dma_reg_wr),
		.cpu_src(cpu_src), .dma_src_ext(dma_src_ext), .ppu_src(ppu_src)
	);

	local_memories u_local_memories (
		.gbclk(gbclk),
		.vram_adr(vram_adr), .vram_rd(vram_rd), .vram_wr(vram_wr), .vram_wdata(vram_wdata),
		.oam_adr(oam_adr), .oam_rd(oam_rd), .oam_wr_en(oam_wr_en),
		.oam_data_in(oam_data_in),
		.hram_adr(hram_adr), .hram_rd(hram_rd), .hram_wr(hram_wr), .hram_wdata(hram_wdata),
		.vram_rdata(vram_rdata), .oam_rdata(oam_rdata), .hram_rdata(hram_rdata)
	);

	read_return u_read_return (
		.gbclk(gbclk), .reset(reset),
		.cpu_src(cpu_src), .dma_src_ext(dma_src_ext), .ppu_src(ppu_src),
		.vram_rdata(vram_rdata), .oam_rdata(oam_rdata), .hram_rdata(hram_rdata),
		.ext_din(ext_din), .dma_reg(dma_reg),
		.cpu_din(cpu_din), .dma_src_data(dma_src_data),
		.ppu_vram_data(ppu_vram_data), .ppu_oam_data(ppu_oam_data)
	);

endmodule

// ==== source/gb_bus_pkg.sv ====
package gb_bus_pkg;

	localparam int ADDR_W  = 16;
	localparam int DATA_W  = 8;
	localparam int VRAM_AW = 13;
	localparam int OAM_AW  = 8;
	localparam int HRAM_AW = 7;

	localparam int VRAM_DEPTH = 8192;
	localparam int OAM_DEPTH  = 160;
	localparam int HRAM_DEPTH = 127;

	localparam logic [ADDR_W-1:0] ROM_END   = 16'h7FFF;
	localparam logic [ADDR_W-1:0] VRAM_BASE = 16'h8000;
	localparam logic [ADDR_W-1:0] VRAM_END  = 16'h9FFF;
	localparam logic [ADDR_W-1:0] XRAM_BASE = 16'hA000;
	localparam logic [ADDR_W-1:0] XRAM_END  = 16'hBFFF;
	localparam logic [ADDR_W-1:0] WRAM_BASE = 16'hC000;
	localparam logic [ADDR_W-1:0] WRAM_END  = 16'hFDFF;   // Echo area counts as work RAM.
	localparam logic [ADDR_W-1:0] OAM_BASE  = 16'hFE00;
	localparam logic [ADDR_W-1:0] OAM_END   = 16'hFE9F;

	localparam logic [7:0] IO_PAGE        = 8'hFF;
	localparam logic [7:0] HRAM_LOW       = 8'h80;
	localparam logic [7:0] HRAM_HIGH      = 8'hFE;
	localparam logic [7:0] DMA_REG_OFFSET = 8'h46;

	localparam logic [DATA_W-1:0] OPEN_BUS = 8'hFF;
	localparam int DMA_LENGTH = 160;

	// Codes for where a granted read takes its data from.
	localparam int SRC_W = 3;
	localparam logic [SRC_W-1:0] SRC_NONE    = 3'd0;
	localparam logic [SRC_W-1:0] SRC_VRAM    = 3'd1;
	localparam logic [SRC_W-1:0] SRC_OAM     = 3'd2;
	localparam logic [SRC_W-1:0] SRC_HRAM    = 3'd3;
	localparam logic [SRC_W-1:0] SRC_EXT     = 3'd4;
	localparam logic [SRC_W-1:0] SRC_DMA_REG = 3'd5;

	typedef union packed {
		logic [ADDR_W-1:0] flat;   // Memory map view.
		struct packed {
			logic [7:0] page;
			logic [7:0] offset;
		} part;                    // I/O page and DMA page view.
	} cpu_addr_t;

endpackage

// ==== source/local_memories.sv ====
`timescale 1ns/1ps

module local_memories import gb_bus_pkg::*; (
	input  logic               gbclk,
	input  logic [VRAM_AW-1:0] vram_adr,
	input  logic               vram_rd,
	input  logic               vram_wr,
	input  logic [DATA_W-1:0]  vram_wdata,
	input  logic [OAM_AW-1:0]  oam_adr,
	input  logic               oam_rd,
	input  logic               oam_wr_en,
	input  logic [DATA_W-1:0]  oam_data_in,
	input  logic [HRAM_AW-1:0] hram_adr,
	input  logic               hram_rd,
	input  logic               hram_wr,
	input  logic [DATA_W-1:0]  hram_wdata,
	output logic [DATA_W-1:0]  vram_rdata,
	output logic [DATA_W-1:0]  oam_rdata,
	output logic [DATA_W-1:0]  hram_rdata
);

	logic [DATA_W-1:0] vram [VRAM_DEPTH];
	logic [DATA_W-1:0] oam  [OAM_DEPTH];
	logic [DATA_W-1:0] hram [HRAM_DEPTH];

	logic oam_in_range;

	assign oam_in_range = int'(oam_adr) < OAM_DEPTH;

	always_ff @(posedge gbclk) begin
		if (vram_wr)
			vram[vram_adr] <= vram_wdata;
		if (vram_rd)
			vram_rdata <= vram[vram_adr];
	end

	// The pixel unit may point past the 160 OAM bytes.
	always_ff @(posedge gbclk) begin
		if (oam_wr_en && oam_in_range)
			oam[oam_adr] <= oam_data_in;
		if (oam_rd)
			oam_rdata <= oam_in_range ? oam[oam_adr] : OPEN_BUS;
	end

	always_ff @(posedge gbclk) begin
		if (hram_wr)
			hram[hram_adr] <= hram_wdata;
		if (hram_rd)
			hram_rdata <= hram[hram_adr];
	end

endmodule

// ==== source/oam_dma_engine.sv ====
`timescale 1ns/1ps

module oam_dma_engine import gb_bus_pkg::*; (
	input  logic              gbclk,
	input  logic              reset,
	input  logic              reg_write,
	input  logic [DATA_W-1:0] reg_data,
	input  logic [DATA_W-1:0] src_data,
	output cpu_addr_t         src_adr,
	output logic              src_rd,
	output logic [OAM_AW-1:0] oam_index,
	output logic              oam_wr,
	output logic [DATA_W-1:0] oam_wdata,
	output logic              dma_active,
	output logic [DATA_W-1:0] dma_reg
);

	logic [7:0]        count;
	logic              reading;
	logic              wr_pending;
	logic [OAM_AW-1:0] wr_index;

	always_ff @(posedge gbclk) begin
		if (reset) begin
			dma_reg    <= '0;
			count      <= '0;
			reading    <= 1'b0;
			wr_pending <= 1'b0;
		end else if (reg_write) begin
			dma_reg    <= reg_data;   // A write while busy restarts at index 0.
			count      <= '0;
			reading    <= 1'b1;
			wr_pending <= 1'b0;
		end else begin
			wr_pending <= reading;
			if (reading) begin
				count <= count + 8'd1;
				if (count == 8'(DMA_LENGTH - 1))
					reading <= 1'b0;
			end
		end
	end

	// The read of one cycle is written to OAM in the next.
	always_ff @(posedge gbclk) begin
		wr_index <= count;
	end

	assign src_adr    = {dma_reg, count};   // Page byte high, offset byte low.
	assign src_rd     = reading;
	assign oam_index  = wr_index;
	assign oam_wr     = wr_pending;
	assign oam_wdata  = src_data;
	assign dma_active = reading || wr_pending;

endmodule

// ==== source/read_return.sv ====
`timescale 1ns/1ps

module read_return import gb_bus_pkg::*; (
	input  logic              gbclk,
	input  logic              reset,
	input  logic [SRC_W-1:0]  cpu_src,
	input  logic [SRC_W-1:0]  dma_src_ext,
	input  logic [1:0]        ppu_src,
	input  logic [DATA_W-1:0] vram_rdata,
	input  logic [DATA_W-1:0] oam_rdata,
	input  logic [DATA_W-1:0] hram_rdata,
	input  logic [DATA_W-1:0] ext_din,
	input  logic [DATA_W-1:0] dma_reg,
	output logic [DATA_W-1:0] cpu_din,
	output logic [DATA_W-1:0] dma_src_data,
	output logic [DATA_W-1:0] ppu_vram_data,
	output logic [DATA_W-1:0] ppu_oam_data
);

	logic [SRC_W-1:0] cpu_src_q;
	logic [SRC_W-1:0] dma_src_q;
	logic [1:0]       ppu_src_q;

	always_ff @(posedge gbclk) begin
		if (reset) begin
			cpu_src_q <= SRC_NONE;
			dma_src_q <= SRC_NONE;
			ppu_src_q <= '0;
		end else begin
			cpu_src_q <= cpu_src;
			dma_src_q <= dma_src_ext;
			ppu_src_q <= ppu_src;
		end
	end

	function automatic logic [DATA_W-1:0] pick(input logic [SRC_W-1:0] src);
		case (src)
			SRC_VRAM:    pick = vram_rdata;
			SRC_OAM:     pick = oam_rdata;
			SRC_HRAM:    pick = hram_rdata;
			SRC_EXT:     pick = ext_din;
			SRC_DMA_REG: pick = dma_reg;
			default:     pick = OPEN_BUS;
		endcase
	endfunction

	always_comb begin
		cpu_din      = pick(cpu_src_q);
		dma_src_data = pick(dma_src_q);
	end

	assign ppu_vram_data = ppu_src_q[0] ? vram_rdata : OPEN_BUS;
	assign ppu_oam_data  = ppu_src_q[1] ? oam_rdata : OPEN_BUS;

endmodule

// ==== verif/tb_gb_bus_tests.svh ====
task automatic begin_test(input string name);
	test_name = name;
	test_errors = 0;
	tests_run++;
endtask

task automatic end_test();
	if (test_errors == 0)
		$display("[PASS] %s", test_name);
	else
		$display("[FAIL] %s: %0d check(s) failed", test_name, test_errors);
endtask

task automatic count_error();
	errors++;
	test_errors++;
endtask

task automatic check_byte(input string what, input logic [DATA_W-1:0] expected,
		input logic [DATA_W-1:0] actual);
	checks++;
	assert (actual === expected)
	else begin
		count_error();
		$display("[FAIL] %s: %s expected 0x%02h actual 0x%02h", test_name, what, expected, actual);
	end
endtask

task automatic check_word(input string what, input logic [15:0] expected,
		input logic [15:0] actual);
	checks++;
	assert (actual === expected)
	else begin
		count_error();
		$display("[FAIL] %s: %s expected 0x%04h actual 0x%04h", test_name, what, expected, actual);
	end
endtask

task automatic check_flag(input string what, input logic expected, input logic actual);
	checks++;
	assert (actual === expected)
	else begin
		count_error();
		$display("[FAIL] %s: %s expected %b actual %b", test_name, what, expected, actual);
	end
endtask

task automatic cpu_write(input logic [ADDR_W-1:0] adr, input logic [DATA_W-1:0] data);
	@(negedge gbclk);
	cpu_adr.flat = adr;
	cpu_dout = data;
	cpu_wr = 1'b1;
	@(negedge gbclk);
	cpu_wr = 1'b0;
endtask

// Data is due half a cycle after the edge that samples the read.
task automatic cpu_read_expect(input logic [ADDR_W-1:0] adr, input logic [DATA_W-1:0] expected);
	@(negedge gbclk);
	cpu_adr.flat = adr;
	cpu_rd = 1'b1;
	@(negedge gbclk);
	check_byte($sformatf("read 0x%04h", adr), expected, cpu_din);
	cpu_rd = 1'b0;
endtask

task automatic ppu_vram_read_expect(input logic [ADDR_W-1:0] adr,
		input logic [DATA_W-1:0] expected);
	@(negedge gbclk);
	ppu_adr = adr;
	ppu_rd = 1'b1;
	@(negedge gbclk);
	check_byte($sformatf("pixel read 0x%04h", adr), expected, ppu_vram_data);
	ppu_rd = 1'b0;
endtask

task automatic ppu_oam_read_expect(input logic [ADDR_W-1:0] adr,
		input logic [DATA_W-1:0] expected);
	@(negedge gbclk);
	ppu_adr = adr;
	ppu_rd = 1'b1;
	@(negedge gbclk);
	check_byte($sformatf("pixel OAM read 0x%04h", adr), expected, ppu_oam_data);
	ppu_rd = 1'b0;
endtask

task automatic ext_write_expect(input logic [ADDR_W-1:0] adr, input logic [DATA_W-1:0] data,
		input logic rom, input logic xram, input logic wram);
	@(negedge gbclk);
	cpu_adr.flat = adr;
	cpu_dout = data;
	cpu_wr = 1'b1;
	#(CLK_PERIOD / 4);   // Bus outputs follow the requester combinationally.
	check_flag("cs_rom", rom, cs_rom);
	check_flag("cs_xram", xram, cs_xram);
	check_flag("cs_wram", wram, cs_wram);
	check_flag("ext_wr", 1'b1, ext_wr);
	check_word("ext_adr", adr, ext_adr);
	check_byte("ext_dout", data, ext_dout);
	@(negedge gbclk);
	cpu_wr = 1'b0;
endtask

task automatic wait_dma_idle(output int cycles);
	cycles = 0;
	while (dma_active && cycles < DMA_TIMEOUT) begin
		@(negedge gbclk);
		cycles++;
	end
	assert (!dma_active)
	else begin
		count_error();
		$display("[FAIL] %s: DMA still active after %0d cycles", test_name, DMA_TIMEOUT);
	end
endtask

function automatic logic [DATA_W-1:0] vram_pattern(input int i);
	return 8'((i * 7 + 33) % 256);
endfunction

task automatic memories_readback();
	begin_test("memories_readback");
	check_flag("dma_active after reset", 1'b0, dma_active);
	check_flag("ext_rd after reset", 1'b0, ext_rd);
	check_flag("ext_wr after reset", 1'b0, ext_wr);
	check_flag("chip selects after reset", 1'b0, cs_rom | cs_xram | cs_wram);
	cpu_read_expect(16'hFF46, 8'h00);
	cpu_write(16'h8123, 8'h3C);
	cpu_write(16'h9FFF, 8'h81);
	cpu_write(16'hFE05, 8'hC3);
	cpu_write(16'hFF80, 8'h5A);
	cpu_write(16'hFFFE, 8'hA7);
	cpu_read_expect(16'h8123, 8'h3C);
	cpu_read_expect(16'h9FFF, 8'h81);
	cpu_read_expect(16'hFE05, 8'hC3);
	cpu_read_expect(16'hFF80, 8'h5A);
	cpu_read_expect(16'hFFFE, 8'hA7);
	end_test();
endtask

task automatic external_routing();
	begin_test("external_routing");
	ext_write_expect(16'h2000, 8'h6D, 1'b1, 1'b0, 1'b0);
	ext_write_expect(16'hA000, 8'h92, 1'b0, 1'b1, 1'b0);
	ext_write_expect(16'hC000, 8'h4E, 1'b0, 1'b0, 1'b1);
	cpu_read_expect(16'hA000, 8'h92);
	cpu_read_expect(16'hC000, 8'h4E);
	cpu_read_expect(16'h1234, ext_mem[16'h1234]);
	cpu_read_expect(16'hE123, ext_mem[16'hE123]);   // Echo area reaches work RAM
	cpu_read_expect(16'hFEA0, OPEN_BUS);
	cpu_read_expect(16'hFF00, OPEN_BUS);
	cpu_read_expect(16'hFFFF, OPEN_BUS);
	end_test();
endtask

task automatic dma_from_external();
	int cycles;
	begin_test("dma_from_external");
	cpu_write(16'hFF46, 8'hC1);
	wait_dma_idle(cycles);
	check_word("dma_active cycles", 16'(DMA_LENGTH + 1), 16'(cycles));
	for (int i = 0; i < DMA_LENGTH; i++)
		cpu_read_expect(16'hFE00 + 16'(i), ext_mem[16'hC100 + 16'(i)]);
	cpu_read_expect(16'hFF46, 8'hC1);
	end_test();
endtask

task automatic dma_from_vram();
	int cycles;
	begin_test("dma_from_vram");
	for (int i = 0; i < DMA_LENGTH; i++)
		cpu_write(16'h8200 + 16'(i), vram_pattern(i));
	cpu_write(16'hFF46, 8'h82);
	wait_dma_idle(cycles);
	for (int i = 0; i < DMA_LENGTH; i++)
		cpu_read_expect(16'hFE00 + 16'(i), vram_pattern(i));
	end_test();
endtask

task automatic bus_contention();
	int cycles;
	begin_test("bus_contention");
	cpu_write(16'hFF46, 8'hC1);
	check_flag("dma_active during transfer", 1'b1, dma_active);
	cpu_read_expect(16'hFE10, OPEN_BUS);   // OAM belongs to the DMA engine.
	cpu_write(16'hFF90, 8'h77);
	cpu_read_expect(16'hFF90, 8'h77);
	wait_dma_idle(cycles);
	cpu_write(16'h8010, 8'hA5);
	cpu_write(16'h8020, 8'h11);
	@(negedge gbclk);
	ppu_needs_vram = 1'b1;
	cpu_read_expect(16'h8020, OPEN_BUS);
	cpu_write(16'h8020, 8'h99);   // Should be lost to the pixel unit.
	ppu_vram_read_expect(16'h8010, 8'hA5);
	@(negedge gbclk);
	ppu_needs_vram = 1'b0;
	cpu_read_expect(16'h8020, 8'h11);
	@(negedge gbclk);
	ppu_needs_oam = 1'b1;
	ppu_oam_read_expect(16'hFE10, ext_mem[16'hC110]);
	@(negedge gbclk);
	ppu_needs_oam = 1'b0;
	end_test();
endtask

// ==== verif/tb_gb_bus_fabric.sv ====
`timescale 1ns/1ps

module tb_gb_bus_fabric import gb_bus_pkg::*; ();

	localparam int CLK_PERIOD  = 20;
	localparam int DMA_TIMEOUT = 400;   // Cycles allowed for one transfer to finish.

	logic              gbclk;
	logic              reset;
	cpu_addr_t         cpu_adr;
	logic [DATA_W-1:0] cpu_dout;
	logic              cpu_rd;
	logic              cpu_wr;
	logic [DATA_W-1:0] cpu_din;
	logic [ADDR_W-1:0] ppu_adr;
	logic              ppu_rd;
	logic              ppu_needs_vram;
	logic              ppu_needs_oam;
	logic [DATA_W-1:0] ppu_vram_data;
	logic [DATA_W-1:0] ppu_oam_data;
	logic [ADDR_W-1:0] ext_adr;
	logic              ext_rd;
	logic              ext_wr;
	logic [DATA_W-1:0] ext_dout;
	logic              cs_rom;
	logic              cs_xram;
	logic              cs_wram;
	logic [DATA_W-1:0] ext_din = '0;
	logic              dma_active;

	logic [DATA_W-1:0] ext_mem [65536];   // Cartridge and work RAM behind the external bus.
	integer            seed = 32'ha58e_f011;

	string test_name;
	int    tests_run;
	int    checks;
	int    errors;
	int    test_errors;

	gb_bus_fabric u_gb_bus_fabric (
		.gbclk(gbclk), .reset(reset),
		.cpu_adr(cpu_adr), .cpu_dout(cpu_dout), .cpu_rd(cpu_rd), .cpu_wr(cpu_wr),
		.cpu_din(cpu_din),
		.ppu_adr(ppu_adr), .ppu_rd(ppu_rd), .ppu_needs_vram(ppu_needs_vram),
		.ppu_needs_oam(ppu_needs_oam), .ppu_vram_data(ppu_vram_data),
		.ppu_oam_data(ppu_oam_data),
		.ext_adr(ext_adr), .ext_rd(ext_rd), .ext_wr(ext_wr), .ext_dout(ext_dout),
		.cs_rom(cs_rom), .cs_xram(cs_xram), .cs_wram(cs_wram), .ext_din(ext_din),
		.dma_active(dma_active)
	);

	initial begin
		gbclk = 1'b0;
		forever #(CLK_PERIOD / 2) gbclk = ~gbclk;
	end

	initial begin
		logic [31:0] rnd;
		for (int i = 0; i < 65536; i++) begin
			rnd = $random(seed);
			ext_mem[i] = rnd[7:0];
		end
	end

	// The external device answers a read on the cycle after ext_rd.
	always @(posedge gbclk) begin
		if (ext_wr)
			ext_mem[ext_adr] = ext_dout;
		if (ext_rd)
			ext_din <= ext_mem[ext_adr];
	end

	`include "tb_gb_bus_tests.svh"

	initial begin
		reset = 1'b1;
		cpu_adr = '0;
		cpu_dout = '0;
		cpu_rd = 1'b0;
		cpu_wr = 1'b0;
		ppu_adr = '0;
		ppu_rd = 1'b0;
		ppu_needs_vram = 1'b0;
		ppu_needs_oam = 1'b0;
		tests_run = 0;
		checks = 0;
		errors = 0;
		test_errors = 0;
		repeat (10) @(negedge gbclk);
		reset = 1'b0;

		memories_readback();
		external_routing();
		dma_from_external();
		dma_from_vram();
		bus_contention();

		$display("Tests run: %0d, checks: %0d, errors: %0d", tests_run, checks, errors);
		if (errors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule
